//--- verilog.f
+incdir+src
+incdir+dv
src/corePkg.sv
src/stageBus.sv
src/pipeRegs.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeUnit.sv
src/executeUnit.sv
src/hazardUnit.sv
src/memUnit.sv
src/rvCore.sv
dv/coreTb.sv

//--- dv/progTable.svh
// Program image and expected retire trace, included into the body of coreTb
`ifndef PROG_TABLE_SVH
`define PROG_TABLE_SVH

localparam int ProgWords = 16;
localparam int TraceLen  = 15;

typedef struct packed {
    corePkg::word_t    pc;
    corePkg::regAddr_t rd;
    corePkg::word_t    data;
    logic              regWrite;
} retire_t;

corePkg::word_t progWords [ProgWords];
retire_t        expTrace [TraceLen];

function automatic retire_t makeEntry(corePkg::word_t pc, corePkg::regAddr_t rd,
                                      corePkg::word_t data, logic regWrite);
    retire_t e;
    e.pc       = pc;
    e.rd       = rd;
    e.data     = data;
    e.regWrite = regWrite;
    return e;
endfunction

task automatic fillTables();
    progWords[0]  = 32'h0070_0013;  // addi x0, x0, 7
    progWords[1]  = 32'h0050_0093;  // addi x1, x0, 5
    progWords[2]  = 32'hFFD0_8113;  // addi x2, x1, -3
    progWords[3]  = 32'h0020_81B3;  // add  x3, x1, x2
    progWords[4]  = 32'h4011_8233;  // sub  x4, x3, x1
    progWords[5]  = 32'h0032_42B3;  // xor  x5, x4, x3
    progWords[6]  = 32'h0052_2333;  // slt  x6, x4, x5
    progWords[7]  = 32'h1234_53B7;  // lui  x7, 0x12345
    progWords[8]  = 32'h0070_2423;  // sw   x7, 8(x0)
    progWords[9]  = 32'h0080_2403;  // lw   x8, 8(x0)
    progWords[10] = 32'h0014_04B3;  // add  x9, x8, x1 (load-use)
    progWords[11] = 32'h0022_1463;  // bne  x4, x2, +8 (not taken)
    progWords[12] = 32'h0080_056F;  // jal  x10, +8
    progWords[13] = 32'h0630_0593;  // addi x11, x0, 99 (jumped over)
    progWords[14] = 32'h0041_0663;  // beq  x2, x4, +12 (taken to 0x44)
    progWords[15] = 32'h04D0_0613;  // addi x12, x0, 77 (branched over)

    // Stores and branches write no register, so only pc is compared for them
    expTrace[0]  = makeEntry(32'h00, 5'd0, 32'd0, 1'b1);  // x0 write reads back 0
    expTrace[1]  = makeEntry(32'h04, 5'd1, 32'd5, 1'b1);
    expTrace[2]  = makeEntry(32'h08, 5'd2, 32'd2, 1'b1);
    expTrace[3]  = makeEntry(32'h0C, 5'd3, 32'd7, 1'b1);
    expTrace[4]  = makeEntry(32'h10, 5'd4, 32'd2, 1'b1);
    expTrace[5]  = makeEntry(32'h14, 5'd5, 32'd5, 1'b1);  // 2 ^ 7
    expTrace[6]  = makeEntry(32'h18, 5'd6, 32'd1, 1'b1);
    expTrace[7]  = makeEntry(32'h1C, 5'd7, 32'h1234_5000, 1'b1);
    expTrace[8]  = makeEntry(32'h20, 5'd0, 32'd0, 1'b0);
    expTrace[9]  = makeEntry(32'h24, 5'd8, 32'h1234_5000, 1'b1);
    expTrace[10] = makeEntry(32'h28, 5'd9, 32'h1234_5005, 1'b1);
    expTrace[11] = makeEntry(32'h2C, 5'd0, 32'd0, 1'b0);
    expTrace[12] = makeEntry(32'h30, 5'd10, 32'h34, 1'b1);  // Link is pc + 4
    expTrace[13] = makeEntry(32'h38, 5'd0, 32'd0, 1'b0);
    expTrace[14] = makeEntry(32'h44, 5'd0, 32'd0, 1'b1);  // NOP past the program
endtask

`endif

//--- dv/coreTb.sv
// Testbench for rvCore: loads the program in reset, then checks each retirement in order
`include "core_defs.svh"

module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rstN;
    logic              imemWe;
    logic [3:0]        imemAddr;
    corePkg::word_t    imemData;
    logic              retireValid;
    corePkg::word_t    retirePc;
    corePkg::regAddr_t retireRd;
    corePkg::word_t    retireData;
    logic              retireRegWrite;

    `include "progTable.svh"

    localparam int MaxCycles = 16 + 3 * TraceLen + 20;

    int errors;
    int traceIdx;
    int cycles;
    int seed;

    rvCore rvCore_inst (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .retireValid(retireValid), .retirePc(retirePc), .retireRd(retireRd),
        .retireData(retireData), .retireRegWrite(retireRegWrite)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Compare one retirement against the next trace entry
    task automatic checkRetire();
        retire_t exp;
        exp = expTrace[traceIdx];
        if (retirePc !== exp.pc) begin
            $display("Error at %0t ns: retire %0d pc %h, expected %h",
                     $time, traceIdx, retirePc, exp.pc);
            errors++;
        end
        if (retireRegWrite !== exp.regWrite) begin
            $display("Error at %0t ns: retire %0d regWrite %b, expected %b",
                     $time, traceIdx, retireRegWrite, exp.regWrite);
            errors++;
        end
        if (exp.regWrite && retireRd !== exp.rd) begin
            $display("Error at %0t ns: retire %0d rd %0d, expected %0d",
                     $time, traceIdx, retireRd, exp.rd);
            errors++;
        end
        if (exp.regWrite && retireData !== exp.data) begin
            $display("Error at %0t ns: retire %0d data %h, expected %h",
                     $time, traceIdx, retireData, exp.data);
            errors++;
        end
        traceIdx++;
    endtask

    // Noise in every data memory word
    task automatic fillDataMem();
        rvCore_inst.memUnit_inst.dmem[0] = $urandom(seed);  // First draw seeds the run
        for (int i = 1; i < `CORE_DMEM_WORDS; i++) begin
            rvCore_inst.memUnit_inst.dmem[i] = $urandom;
        end
    endtask

    initial begin
        errors   = 0;
        traceIdx = 0;
        cycles   = 0;
        seed     = 36;
        fillTables();
        rstN     = 1'b0;
        imemWe   = 1'b1;
        imemAddr = 4'd0;
        imemData = '0;
        fillDataMem();

        for (int i = 0; i < ProgWords; i++) begin
            imemAddr = i[3:0];
            imemData = progWords[i];
            @(posedge clk);
            #2;
            cycles++;
            if (retireValid !== 1'b0) begin
                $display("Error at %0t ns: retireValid high during reset", $time);
                errors++;
            end
        end
        rstN   = 1'b1;
        imemWe = 1'b0;

        while (traceIdx < TraceLen && cycles < MaxCycles) begin
            @(posedge clk);
            #2;
            cycles++;
            if (retireValid === 1'b1) begin
                checkRetire();
            end
        end

        if (traceIdx < TraceLen) begin
            $display("timeout: retire trace incomplete, %0d of %0d seen after %0d cycles",
                     traceIdx, TraceLen, cycles);
            errors++;
        end
        $display("Summary: %0d errors, %0d of %0d retirements checked in %0d cycles",
                 errors, traceIdx, TraceLen, cycles);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

//--- src/rvCore.sv
// Five-stage RV32I subset core; the testbench loads imem in reset and watches retire
module rvCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  logic [3:0]        imemAddr,
    input  corePkg::word_t    imemData,
    output logic              retireValid,
    output corePkg::word_t    retirePc,
    output corePkg::regAddr_t retireRd,
    output corePkg::word_t    retireData,
    output logic              retireRegWrite
);
    corePkg::word_t    fetchInstr, fetchPc, idInstr, idPc;
    corePkg::word_t    rData1, rData2, redirectPc;
    corePkg::regAddr_t rs1, rs2;
    corePkg::fwdSel_e  fwdA, fwdB;
    logic              idValid, stall, flushIfId, flushIdEx, redirect;

    idExBus  idExD ();
    idExBus  idExQ ();
    exMemBus exMemD ();
    exMemBus exMemQ ();
    memWbBus memWbD ();
    memWbBus memWbQ ();

    fetchUnit fetchUnit_inst (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
        .instr(fetchInstr), .pc(fetchPc)
    );

    ifIdReg ifIdReg_inst (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flushIfId),
        .instr(fetchInstr), .pc(fetchPc),
        .idInstr(idInstr), .idPc(idPc), .idValid(idValid)
    );

    decodeUnit decodeUnit_inst (
        .instr(idInstr), .pc(idPc), .valid(idValid), .rData1(rData1), .rData2(rData2),
        .rs1(rs1), .rs2(rs2), .out(idExD)
    );

    regFile regFile_inst (
        .clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2),
        .we(memWbQ.regWrite), .rd(memWbQ.rd), .wData(memWbQ.result),
        .rData1(rData1), .rData2(rData2)
    );

    idExReg idExReg_inst (
        .clk(clk), .rstN(rstN), .flush(flushIdEx), .in(idExD), .out(idExQ)
    );

    executeUnit executeUnit_inst (
        .in(idExQ), .fwdA(fwdA), .fwdB(fwdB),
        .exMemResult(exMemQ.aluResult), .memWbResult(memWbQ.result),
        .out(exMemD), .redirect(redirect), .redirectPc(redirectPc)
    );

    exMemReg exMemReg_inst (.clk(clk), .rstN(rstN), .in(exMemD), .out(exMemQ));

    memUnit memUnit_inst (.clk(clk), .in(exMemQ), .out(memWbD));

    memWbReg memWbReg_inst (.clk(clk), .rstN(rstN), .in(memWbD), .out(memWbQ));

    hazardUnit hazardUnit_inst (
        .idRs1(rs1), .idRs2(rs2),
        .exRs1(idExQ.rs1), .exRs2(idExQ.rs2), .exRd(idExQ.rd),
        .exMemRead(idExQ.memRead), .exValid(idExQ.valid),
        .memRd(exMemQ.rd), .memRegWrite(exMemQ.regWrite),
        .wbRd(memWbQ.rd), .wbRegWrite(memWbQ.regWrite), .redirect(redirect),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall),
        .flushIfId(flushIfId), .flushIdEx(flushIdEx)
    );

    // Retire straight from MEM/WB
    assign retireValid    = memWbQ.valid;
    assign retirePc       = memWbQ.pc;
    assign retireRd       = memWbQ.rd;
    assign retireData     = memWbQ.result;
    assign retireRegWrite = memWbQ.regWrite;
endmodule

//--- src/memUnit.sv
// MEM stage: word-addressed data memory and result selection for writeback
`include "core_defs.svh"

module memUnit (
    input logic clk,
    exMemBus.dst in,
    memWbBus.src out
);
    corePkg::word_t dmem [`CORE_DMEM_WORDS];
    corePkg::word_t loadData, sel;

    always_ff @(posedge clk) begin
        if (in.valid && in.memWrite) begin
            dmem[in.aluResult[7:2]] <= in.storeData;
        end
    end

    assign loadData = in.memRead ? dmem[in.aluResult[7:2]] : '0;
    assign sel      = (in.wbSel == corePkg::WB_LOAD) ? loadData : in.aluResult;

    assign out.valid    = in.valid;
    assign out.pc       = in.pc;
    assign out.rd       = in.rd;
    assign out.regWrite = in.regWrite;
    assign out.result   = (in.regWrite && in.rd == '0) ? '0 : sel;  // x0 stays zero
endmodule

//--- src/hazardUnit.sv
// Forwarding selection, load-use stall and redirect flush control
module hazardUnit (
    input  corePkg::regAddr_t idRs1,
    input  corePkg::regAddr_t idRs2,
    input  corePkg::regAddr_t exRs1,
    input  corePkg::regAddr_t exRs2,
    input  corePkg::regAddr_t exRd,
    input  logic              exMemRead,
    input  logic              exValid,
    input  corePkg::regAddr_t memRd,
    input  logic              memRegWrite,
    input  corePkg::regAddr_t wbRd,
    input  logic              wbRegWrite,
    input  logic              redirect,
    output corePkg::fwdSel_e  fwdA,
    output corePkg::fwdSel_e  fwdB,
    output logic              stall,
    output logic              flushIfId,
    output logic              flushIdEx
);
    logic loadUse;

    // Youngest producer wins
    function automatic corePkg::fwdSel_e pick(corePkg::regAddr_t rs);
        if (memRegWrite && memRd != '0 && memRd == rs) return corePkg::FWD_EXMEM;
        if (wbRegWrite && wbRd != '0 && wbRd == rs) return corePkg::FWD_MEMWB;
        return corePkg::FWD_REG;
    endfunction

    always_comb begin
        fwdA = pick(exRs1);
        fwdB = pick(exRs2);
    end

    assign loadUse   = exValid && exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);
    assign stall     = loadUse;
    assign flushIfId = redirect;
    assign flushIdEx = redirect || loadUse;  // Bubble behind the load
endmodule

//--- src/executeUnit.sv
// EX stage: operand forwarding, ALU and branch or jump resolution
module executeUnit (
    idExBus.dst in,
    input  corePkg::fwdSel_e fwdA,
    input  corePkg::fwdSel_e fwdB,
    input  corePkg::word_t   exMemResult,
    input  corePkg::word_t   memWbResult,
    exMemBus.src out,
    output logic             redirect,
    output corePkg::word_t   redirectPc
);
    corePkg::word_t opA, opB, aluB, aluRes;
    logic taken;

    function automatic corePkg::word_t fwdMux(corePkg::fwdSel_e sel, corePkg::word_t regVal,
                                              corePkg::word_t exMem, corePkg::word_t memWb);
        case (sel)
            corePkg::FWD_EXMEM: return exMem;
            corePkg::FWD_MEMWB: return memWb;
            default:            return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdA, in.rData1, exMemResult, memWbResult);
    assign opB  = fwdMux(fwdB, in.rData2, exMemResult, memWbResult);
    assign aluB = in.useImm ? in.imm : opB;

    always_comb begin
        case (in.aluOp)
            corePkg::ALU_SUB:   aluRes = opA - aluB;
            corePkg::ALU_AND:   aluRes = opA & aluB;
            corePkg::ALU_OR:    aluRes = opA | aluB;
            corePkg::ALU_XOR:   aluRes = opA ^ aluB;
            corePkg::ALU_SLT:   aluRes = {31'b0, $signed(opA) < $signed(aluB)};
            corePkg::ALU_PASSB: aluRes = aluB;
            default:            aluRes = opA + aluB;
        endcase
    end

    assign taken      = in.branch && ((opA == opB) != in.branchNe);
    assign redirect   = in.valid && (taken || in.jump);
    assign redirectPc = in.pc + in.imm;

    assign out.valid     = in.valid;
    assign out.pc        = in.pc;
    assign out.rd        = in.rd;
    assign out.aluResult = (in.wbSel == corePkg::WB_PC4) ? in.pc + 32'd4 : aluRes;  // JAL link
    assign out.storeData = opB;
    assign out.regWrite  = in.regWrite;
    assign out.memRead   = in.memRead;
    assign out.memWrite  = in.memWrite;
    assign out.wbSel     = in.wbSel;
endmodule

//--- src/decodeUnit.sv
// Decoder for the supported RV32I subset, feeding the ID/EX register
module decodeUnit (
    input  corePkg::word_t    instr,
    input  corePkg::word_t    pc,
    input  logic              valid,
    input  corePkg::word_t    rData1,
    input  corePkg::word_t    rData2,
    output corePkg::regAddr_t rs1,
    output corePkg::regAddr_t rs2,
    idExBus.src out
);
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    logic [2:0] funct3;
    logic       known;

    assign funct3     = instr[14:12];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign out.pc     = pc;
    assign out.rs1    = rs1;
    assign out.rs2    = rs2;
    assign out.rd     = instr[11:7];
    assign out.rData1 = rData1;
    assign out.rData2 = rData2;
    assign out.valid  = valid && known;

    always_comb begin
        known        = 1'b1;
        out.aluOp    = corePkg::ALU_ADD;
        out.useImm   = 1'b0;
        out.regWrite = 1'b0;
        out.memRead  = 1'b0;
        out.memWrite = 1'b0;
        out.wbSel    = corePkg::WB_ALU;
        out.branch   = 1'b0;
        out.branchNe = funct3[0];
        out.jump     = 1'b0;
        out.imm      = {{20{instr[31]}}, instr[31:20]};  // I-type
        case (instr[6:0])
            OpReg: begin
                out.regWrite = 1'b1;
                case (funct3)
                    3'b000:  out.aluOp = instr[30] ? corePkg::ALU_SUB : corePkg::ALU_ADD;
                    3'b111:  out.aluOp = corePkg::ALU_AND;
                    3'b110:  out.aluOp = corePkg::ALU_OR;
                    3'b100:  out.aluOp = corePkg::ALU_XOR;
                    3'b010:  out.aluOp = corePkg::ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OpImm: begin  // ADDI only
                out.regWrite = 1'b1;
                out.useImm   = 1'b1;
                known        = (funct3 == 3'b000);
            end
            OpLui: begin
                out.regWrite = 1'b1;
                out.useImm   = 1'b1;
                out.aluOp    = corePkg::ALU_PASSB;
                out.imm      = {instr[31:12], 12'b0};
            end
            OpLoad: begin
                out.regWrite = 1'b1;
                out.useImm   = 1'b1;
                out.memRead  = 1'b1;
                out.wbSel    = corePkg::WB_LOAD;
                known        = (funct3 == 3'b010);
            end
            OpStore: begin
                out.useImm   = 1'b1;
                out.memWrite = 1'b1;
                out.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                known        = (funct3 == 3'b010);
            end
            OpBranch: begin  // BEQ and BNE
                out.branch = 1'b1;
                out.imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                known      = (funct3[2:1] == 2'b00);
            end
            OpJal: begin
                out.jump     = 1'b1;
                out.regWrite = 1'b1;
                out.wbSel    = corePkg::WB_PC4;
                out.imm      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
            end
            default: known = 1'b0;
        endcase
        // Anything not decoded becomes a bubble
        if (!(valid && known)) begin
            out.regWrite = 1'b0;
            out.memRead  = 1'b0;
            out.memWrite = 1'b0;
            out.branch   = 1'b0;
            out.jump     = 1'b0;
        end
    end
endmodule

//--- src/regFile.sv
// Integer register file read in ID and written from MEM/WB
module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::regAddr_t rs1,
    input  corePkg::regAddr_t rs2,
    input  logic              we,
    input  corePkg::regAddr_t rd,
    input  corePkg::word_t    wData,
    output corePkg::word_t    rData1,
    output corePkg::word_t    rData2
);
    corePkg::word_t regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wData;
        end
    end

    // Same-cycle write shows up on the read side
    assign rData1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wData : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wData : regs[rs2];
endmodule

//--- src/fetchUnit.sv
// PC register and instruction memory, loaded through the port while reset is held
`include "core_defs.svh"

module fetchUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           imemWe,
    input  logic [3:0]     imemAddr,
    input  corePkg::word_t imemData,
    input  logic           stall,
    input  logic           redirect,
    input  corePkg::word_t redirectPc,
    output corePkg::word_t instr,
    output corePkg::word_t pc
);
    corePkg::word_t imem [`CORE_IMEM_WORDS];

    // Program load only during reset
    always_ff @(posedge clk) begin
        if (imemWe && !rstN) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `CORE_RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign instr = (pc[31:2] < `CORE_IMEM_WORDS) ? imem[pc[5:2]] : `CORE_NOP;
endmodule

//--- src/pipeRegs.sv
// The four pipeline stage registers, instantiated once each by rvCore
`include "core_defs.svh"

module ifIdReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           stall,
    input  logic           flush,
    input  corePkg::word_t instr,
    input  corePkg::word_t pc,
    output corePkg::word_t idInstr,
    output corePkg::word_t idPc,
    output logic           idValid
);
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idInstr <= `CORE_NOP;
            idValid <= 1'b0;
        end else if (flush) begin  // Flush wins over stall
            idInstr <= `CORE_NOP;
            idValid <= 1'b0;
        end else if (!stall) begin
            idInstr <= instr;
            idValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush || !stall) begin
            idPc <= pc;
        end
    end
endmodule

module idExReg (
    input logic clk,
    input logic rstN,
    input logic flush,  // Redirect or load-use bubble
    idExBus.dst in,
    idExBus.src out
);
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out.valid    <= 1'b0;
            out.regWrite <= 1'b0;
            out.memRead  <= 1'b0;
            out.memWrite <= 1'b0;
            out.branch   <= 1'b0;
            out.jump     <= 1'b0;
        end else begin
            out.valid    <= in.valid && !flush;
            out.regWrite <= in.regWrite && !flush;
            out.memRead  <= in.memRead && !flush;
            out.memWrite <= in.memWrite && !flush;
            out.branch   <= in.branch && !flush;
            out.jump     <= in.jump && !flush;
        end
    end

    always_ff @(posedge clk) begin
        out.pc       <= in.pc;
        out.rs1      <= in.rs1;
        out.rs2      <= in.rs2;
        out.rd       <= in.rd;
        out.rData1   <= in.rData1;
        out.rData2   <= in.rData2;
        out.imm      <= in.imm;
        out.aluOp    <= in.aluOp;
        out.useImm   <= in.useImm;
        out.wbSel    <= in.wbSel;
        out.branchNe <= in.branchNe;
    end
endmodule

module exMemReg (
    input logic clk,
    input logic rstN,
    exMemBus.dst in,
    exMemBus.src out
);
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out.valid    <= 1'b0;
            out.regWrite <= 1'b0;
            out.memRead  <= 1'b0;
            out.memWrite <= 1'b0;
        end else begin
            out.valid    <= in.valid;
            out.regWrite <= in.regWrite;
            out.memRead  <= in.memRead;
            out.memWrite <= in.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        out.pc        <= in.pc;
        out.rd        <= in.rd;
        out.aluResult <= in.aluResult;
        out.storeData <= in.storeData;
        out.wbSel     <= in.wbSel;
    end
endmodule

module memWbReg (
    input logic clk,
    input logic rstN,
    memWbBus.dst in,
    memWbBus.src out
);
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out.valid    <= 1'b0;
            out.regWrite <= 1'b0;
        end else begin
            out.valid    <= in.valid;
            out.regWrite <= in.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        out.pc     <= in.pc;
        out.rd     <= in.rd;
        out.result <= in.result;
    end
endmodule

//--- src/stageBus.sv
// Instruction bundles passed between pipeline stages, instantiated inside rvCore
interface idExBus;
    logic              valid;
    corePkg::word_t    pc;
    corePkg::regAddr_t rs1, rs2, rd;
    corePkg::word_t    rData1, rData2, imm;
    corePkg::aluOp_e   aluOp;
    logic              useImm, regWrite, memRead, memWrite;
    corePkg::wbSel_e   wbSel;
    logic              branch, branchNe, jump;

    modport src (output valid, pc, rs1, rs2, rd, rData1, rData2, imm, aluOp, useImm,
                 regWrite, memRead, memWrite, wbSel, branch, branchNe, jump);
    modport dst (input valid, pc, rs1, rs2, rd, rData1, rData2, imm, aluOp, useImm,
                 regWrite, memRead, memWrite, wbSel, branch, branchNe, jump);
endinterface

interface exMemBus;
    logic              valid;
    corePkg::word_t    pc;
    corePkg::regAddr_t rd;
    corePkg::word_t    aluResult, storeData;
    logic              regWrite, memRead, memWrite;
    corePkg::wbSel_e   wbSel;

    modport src (output valid, pc, rd, aluResult, storeData, regWrite, memRead, memWrite,
                 wbSel);
    modport dst (input valid, pc, rd, aluResult, storeData, regWrite, memRead, memWrite,
                 wbSel);
endinterface

interface memWbBus;
    logic              valid;
    corePkg::word_t    pc;
    corePkg::regAddr_t rd;
    corePkg::word_t    result;
    logic              regWrite;

    modport src (output valid, pc, rd, result, regWrite);
    modport dst (input valid, pc, rd, result, regWrite);
endinterface

//--- src/corePkg.sv
// Shared vector types and control enums, referenced by scoped name across the core
package corePkg;

    typedef logic [31:0] word_t;    // Data, address or instruction
    typedef logic [4:0]  regAddr_t;

    // EX operand source
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSel_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } aluOp_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4
    } wbSel_e;

endpackage

//--- src/core_defs.svh
// Core sizes and fixed encodings, included by the RTL files that need them
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_IMEM_WORDS 16
`define CORE_DMEM_WORDS 64
`define CORE_RESET_PC   32'h0000_0000
`define CORE_NOP        32'h0000_0013  // ADDI x0, x0, 0

`endif
